//--- Makefile
# Verilator flow for the Hilbert transformer testbench.
# Any variable below can be overridden on the make command line.
TOP ?= hilbertTransformTb
BUILD_DIR ?= build
LOG ?= sim.log
FILE_LIST ?= build.f
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Testbench passed

.PHONY: compile run clean

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

# The simulator's own exit status is ignored; the log decides pass or fail.
run: compile
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- build.f
+incdir+design
design/hilbertPkg.sv
design/hilbertControl.sv
design/coeffLoader.sv
design/firFilter.sv
design/delayLine.sv
design/hilbertTransform.sv
tb/hilbertTransformTb.sv

//--- design/coeffLoader.sv
`timescale 1ns/1ns
`include "hilbert_settings.svh"

module coeffLoader (
	input logic clock,
	input logic rstN,
	input logic loadStart,
	output logic coeffWrite,
	output hilbertPkg::coeffType coeffData,
	output logic coeffDone
);
	import hilbertPkg::*;

	localparam int indexWidth = $clog2(`HT_LENGTH);
	localparam logic [indexWidth-1:0] lastTap = indexWidth'(`HT_LENGTH - 1);
	localparam real pi = 3.14159265358979323846;

	// The ideal Hilbert response is 2/(pi*k) for odd offsets k and zero for even ones.
	// Ties round away from zero.
	function automatic coeffType kernelTap(input int j);
		int k;
		real scaled;
		real rounded;
		k = j - `HT_CENTER;
		if (k % 2 == 0) begin
			return '0;
		end
		scaled = (2.0 ** `HT_COEFF_FRAC) * 2.0 / (pi * k);
		rounded = (scaled >= 0.0) ? $floor(scaled + 0.5) : -$floor(0.5 - scaled);
		return coeffType'($rtoi(rounded));
	endfunction

	coeffType kernel [`HT_LENGTH];
	logic [indexWidth-1:0] tapIndex;

	// Every table entry is a constant fixed at elaboration.
	for (genvar j = 0; j < `HT_LENGTH; j++) begin : gKernel
		localparam coeffType tapValue = kernelTap(j);
		assign kernel[j] = tapValue;
	end

	// Tap 0 goes out first, one tap per cycle.
	assign coeffData = kernel[tapIndex];
	assign coeffDone = coeffWrite && (tapIndex == lastTap);

	always_ff @(posedge clock) begin
		if (!rstN) begin
			coeffWrite <= 1'b0;
			tapIndex <= '0;
		end else if (loadStart) begin
			coeffWrite <= 1'b1;
			tapIndex <= '0;
		end else if (coeffWrite) begin
			if (tapIndex == lastTap) begin
				coeffWrite <= 1'b0;
				tapIndex <= '0;
			end else begin
				tapIndex <= tapIndex + 1'b1;
			end
		end
	end

endmodule

//--- design/delayLine.sv
`timescale 1ns/1ns
`include "hilbert_settings.svh"

module delayLine (
	input logic clock,
	input logic rstN,
	input logic clearHistory,
	input logic shiftEn,
	input logic zeroOut,
	input hilbertPkg::sampleType dataIn,
	output hilbertPkg::resultType dataOutRe
);
	import hilbertPkg::*;

	// history[0] holds x[n-1] and history[HT_CENTER-1] holds x[n-HT_CENTER].
	sampleType history [`HT_CENTER];

	always_ff @(posedge clock) begin
		if (clearHistory) begin
			for (int i = 0; i < `HT_CENTER; i++) begin
				history[i] <= '0;
			end
		end else if (shiftEn) begin
			history[0] <= dataIn;
			for (int i = 1; i < `HT_CENTER; i++) begin
				history[i] <= history[i-1];
			end
		end
	end

	// The oldest sample is moved up to the coefficient scale.
	// This way both outputs share one fixed-point format.
	always_ff @(posedge clock) begin
		if (!rstN || zeroOut) begin
			dataOutRe <= '0;
		end else begin
			dataOutRe <= resultType'(history[`HT_CENTER-1]) <<< `HT_COEFF_FRAC;
		end
	end

endmodule

//--- design/firFilter.sv
`timescale 1ns/1ns
`include "hilbert_settings.svh"

module firFilter (
	input logic clock,
	input logic rstN,
	input logic clearHistory,
	input logic coeffWrite,
	input logic shiftEn,
	input logic zeroOut,
	input hilbertPkg::coeffType coeffData,
	input hilbertPkg::sampleType dataIn,
	output hilbertPkg::resultType dataOutIm
);
	import hilbertPkg::*;

	// Coefficient bank in which coeffReg[j] weights x[n-j].
	coeffType coeffReg [`HT_LENGTH];

	// Previous samples with history[0] holding x[n-1].
	// Together with dataIn this forms the full HT_LENGTH window, so the output
	// for a sample is ready at the same edge that accepts it.
	sampleType history [`HT_LENGTH-1];

	resultType sumNext;

	// Writes enter at the top and move down.
	// After HT_LENGTH writes, the first coefficient sent sits in coeffReg[0].
	always_ff @(posedge clock) begin
		if (coeffWrite) begin
			coeffReg[`HT_LENGTH-1] <= coeffData;
			for (int i = 0; i < `HT_LENGTH - 1; i++) begin
				coeffReg[i] <= coeffReg[i+1];
			end
		end
	end

	// History is emptied while idle and shifts once per accepted sample.
	always_ff @(posedge clock) begin
		if (clearHistory) begin
			for (int i = 0; i < `HT_LENGTH - 1; i++) begin
				history[i] <= '0;
			end
		end else if (shiftEn) begin
			history[0] <= dataIn;
			for (int i = 1; i < `HT_LENGTH - 1; i++) begin
				history[i] <= history[i-1];
			end
		end
	end

	// Full-width products are summed without saturation.
	// The input bound keeps the total inside resultType.
	always_comb begin
		sumNext = resultType'(coeffReg[0]) * resultType'(dataIn);
		for (int j = 1; j < `HT_LENGTH; j++) begin
			sumNext += resultType'(coeffReg[j]) * resultType'(history[j-1]);
		end
	end

	// Quadrature output register.
	// Every edge that is not zeroed accepts a sample.
	always_ff @(posedge clock) begin
		if (!rstN || zeroOut) begin
			dataOutIm <= '0;
		end else begin
			dataOutIm <= sumNext;
		end
	end

endmodule

//--- design/hilbertControl.sv
`timescale 1ns/1ns
`include "hilbert_settings.svh"

module hilbertControl (
	input logic clock,
	input logic rstN,
	input logic enable,
	input logic stopDataIn,
	input logic coeffDone,
	output logic loadStart,
	output logic shiftEn,
	output logic clearHistory,
	output logic outValid,
	output logic zeroOut
);
	import hilbertPkg::*;

	// The fill counter must be able to hold HT_LENGTH itself.
	localparam int countWidth = $clog2(`HT_LENGTH + 1);
	// Count value seen at the edge that accepts the last sample of the first window.
	localparam logic [countWidth-1:0] lastFill = countWidth'(`HT_LENGTH - 1);

	ctrlState state;
	logic [countWidth-1:0] fillCount;
	logic streaming;
	logic accept;

	// Samples are taken in FILL and RUN only.
	assign streaming = (state == FILL) || (state == RUN);

	// A raised stop refuses the sample in the same cycle, so the sample at the stop
	// edge never reaches the tap history.
	assign accept = streaming && !stopDataIn;

	// The shift enable is the sampleReady level seen at the top level.
	assign shiftEn = accept;

	// History is wiped for as long as the block sits idle.
	// A restart therefore always begins from an empty window.
	assign clearHistory = (state == IDLE);

	// RUN is entered at the edge that registers the output of the
	// HT_LENGTH-th sample, so valid simply follows the state.
	assign outValid = (state == RUN);

	// Output registers load zero on every edge without an accepted sample.
	// This covers IDLE, LOAD, STOP and the stop edge itself.
	assign zeroOut = !accept;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			state <= IDLE;
			loadStart <= 1'b0;
			fillCount <= '0;
		end else begin
			// The load request is a single cycle pulse.
			loadStart <= 1'b0;
			case (state)
				IDLE: begin
					fillCount <= '0;
					if (enable) begin
						state <= LOAD;
						loadStart <= 1'b1;
					end
				end
				// The loader flags the last coefficient write itself.
				LOAD: begin
					if (coeffDone) begin
						state <= FILL;
					end
				end
				FILL: begin
					if (stopDataIn) begin
						state <= STOP;
					end else begin
						fillCount <= fillCount + 1'b1;
						if (fillCount == lastFill) begin
							state <= RUN;
						end
					end
				end
				RUN: begin
					if (stopDataIn) begin
						state <= STOP;
					end
				end
				// Stay stopped until enable is released.
				STOP: begin
					if (!enable) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

//--- design/hilbertPkg.sv
`include "hilbert_settings.svh"

package hilbertPkg;

	// One input sample in two's complement.
	typedef logic signed [`HT_DATA_WIDTH-1:0] sampleType;

	// One kernel coefficient.
	// The low HT_COEFF_FRAC bits are the fraction.
	typedef logic signed [`HT_DATA_WIDTH-1:0] coeffType;

	// Output word, wide enough for a full product.
	// The sum of all products fits as long as inputs respect the input bound.
	typedef logic signed [2*`HT_DATA_WIDTH-1:0] resultType;

	// Control states run from waiting through loading, filling and streaming to stopped.
	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		FILL,
		RUN,
		STOP
	} ctrlState;

endpackage

//--- design/hilbertTransform.sv
`timescale 1ns/1ns

module hilbertTransform (
	input logic clock,
	input logic rstN,
	input logic enable,
	input logic stopDataIn,
	input hilbertPkg::sampleType dataIn,
	output logic sampleReady,
	output logic outValid,
	output hilbertPkg::resultType dataOutRe,
	output hilbertPkg::resultType dataOutIm
);
	import hilbertPkg::*;

	logic loadStart;
	logic coeffWrite;
	coeffType coeffData;
	logic coeffDone;
	logic clearHistory;
	logic zeroOut;

	// Sequencing.
	// The shift enable leaves the block directly as sampleReady.
	hilbertControl i_control (
		.clock(clock),
		.rstN(rstN),
		.enable(enable),
		.stopDataIn(stopDataIn),
		.coeffDone(coeffDone),
		.loadStart(loadStart),
		.shiftEn(sampleReady),
		.clearHistory(clearHistory),
		.outValid(outValid),
		.zeroOut(zeroOut)
	);

	// Kernel source, one tap per cycle after each start.
	coeffLoader i_loader (
		.clock(clock),
		.rstN(rstN),
		.loadStart(loadStart),
		.coeffWrite(coeffWrite),
		.coeffData(coeffData),
		.coeffDone(coeffDone)
	);

	// Quadrature path.
	firFilter i_filter (
		.clock(clock),
		.rstN(rstN),
		.clearHistory(clearHistory),
		.coeffWrite(coeffWrite),
		.shiftEn(sampleReady),
		.zeroOut(zeroOut),
		.coeffData(coeffData),
		.dataIn(dataIn),
		.dataOutIm(dataOutIm)
	);

	// In-phase path, delayed to match the filter's centre tap.
	delayLine i_delay (
		.clock(clock),
		.rstN(rstN),
		.clearHistory(clearHistory),
		.shiftEn(sampleReady),
		.zeroOut(zeroOut),
		.dataIn(dataIn),
		.dataOutRe(dataOutRe)
	);

endmodule

//--- design/hilbert_settings.svh
`ifndef HILBERT_SETTINGS_SVH
`define HILBERT_SETTINGS_SVH

// Number of filter taps.
// The kernel is antisymmetric about a single centre tap, so this must be odd.
`define HT_LENGTH 27

// Width of one input sample and of one stored coefficient.
`define HT_DATA_WIDTH 18

// A coefficient carries this many fraction bits and represents 1.0 as 2^16.
`define HT_COEFF_FRAC 16

// Index of the centre tap.
// This is also the group delay of the filter in accepted samples.
`define HT_CENTER ((`HT_LENGTH - 1) / 2)

`endif

//--- tb/hilbertTransformTb.sv
`timescale 1ns/1ns
`include "hilbert_settings.svh"

module hilbertTransformTb;
	import hilbertPkg::*;

	// Ways an entry produces its samples.
	localparam int modeConst = 0;
	localparam int modeImpulse = 1;
	localparam int modeRandom = 2;
	localparam int modeWait = 3;

	// Each table row holds the input levels, the sample source, the length and
	// the sampleReady level expected on the row's last cycle.
	typedef struct {
		logic en;
		logic stop;
		int mode;
		int value;
		int count;
		logic readyAtEnd;
	} stepEntry;

	logic clock;
	logic rstN;
	logic enable;
	logic stopDataIn;
	sampleType dataIn;
	logic sampleReady;
	logic outValid;
	resultType dataOutRe;
	resultType dataOutIm;

	stepEntry stimulus [$];
	longint kernel [`HT_LENGTH];
	// Model history with hist[0] as the newest accepted sample.
	longint hist [`HT_LENGTH];
	int accepted;
	logic pendAccept;
	logic pendEnable;
	sampleType pendSample;
	logic stopSeen;
	logic [31:0] lfsrState;
	int valueErrors;
	int otherErrors;
	int limitCycles;

	hilbertTransform i_dut (
		.clock(clock),
		.rstN(rstN),
		.enable(enable),
		.stopDataIn(stopDataIn),
		.dataIn(dataIn),
		.sampleReady(sampleReady),
		.outValid(outValid),
		.dataOutRe(dataOutRe),
		.dataOutIm(dataOutIm)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// The limit is set once the table is built.
	initial begin
		wait (limitCycles > 0);
		#(limitCycles * 20);
		$display("Timeout: the stimulus table did not finish within %0d cycles.", limitCycles);
		$display("Testbench failed");
		$finish;
	end

	// Galois LFSR stepped once per bit taken.
	function automatic logic nextLfsrBit();
		logic outBit;
		outBit = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (outBit) begin
			lfsrState = lfsrState ^ 32'h8020_0003;
		end
		return outBit;
	endfunction

	// A signed word two bits narrower than a sample stays inside the input bound.
	function automatic sampleType randomSample();
		logic [`HT_DATA_WIDTH-3:0] bits;
		for (int b = 0; b < `HT_DATA_WIDTH - 2; b++) begin
			bits[b] = nextLfsrBit();
		end
		return sampleType'($signed(bits));
	endfunction

	// Nearest integer with halves away from zero.
	function automatic longint roundAway(input real x);
		if (x >= 0.0) begin
			return $rtoi(x + 0.5);
		end
		return -$rtoi(0.5 - x);
	endfunction

	// Ideal Hilbert tap that is zero on even offsets from the centre.
	function automatic longint refTap(input int j);
		int k;
		k = j - `HT_CENTER;
		if (k % 2 == 0) begin
			return 0;
		end
		return roundAway((2.0 ** `HT_COEFF_FRAC) * 2.0 / (3.14159265358979 * k));
	endfunction

	task automatic reportMismatch(input string name, input longint expected,
			input longint actual);
		valueErrors++;
		$display("[FAIL] %0t %s expected %0d got %0d", $time, name, expected, actual);
	endtask

	task automatic addEntry(input logic en, input logic stop, input int mode, input int value,
			input int count, input logic readyAtEnd);
		stepEntry entry;
		entry.en = en;
		entry.stop = stop;
		entry.mode = mode;
		entry.value = value;
		entry.count = count;
		entry.readyAtEnd = readyAtEnd;
		stimulus.push_back(entry);
	endtask

	// Applies the edge that just happened to the model, then compares.
	// Outputs of an accepted sample are checked in every cycle, so a restart
	// is checked against an empty history long before outValid rises.
	task automatic checkOutputs();
		longint expIm;
		longint expRe;
		logic expValid;
		if (!pendEnable) begin
			accepted = 0;
			foreach (hist[i]) begin
				hist[i] = 0;
			end
		end
		if (pendAccept) begin
			for (int i = `HT_LENGTH - 1; i > 0; i--) begin
				hist[i] = hist[i-1];
			end
			hist[0] = pendSample;
			accepted++;
		end
		expIm = 0;
		expRe = 0;
		if (pendAccept) begin
			foreach (kernel[j]) begin
				expIm += kernel[j] * hist[j];
			end
			expRe = hist[`HT_CENTER] * (longint'(1) << `HT_COEFF_FRAC);
		end
		expValid = pendAccept && (accepted >= `HT_LENGTH);
		assert (outValid === expValid) else
			reportMismatch("outValid", longint'(expValid), longint'(outValid));
		assert (dataOutIm == expIm) else reportMismatch("dataOutIm", expIm, dataOutIm);
		assert (dataOutRe == expRe) else reportMismatch("dataOutRe", expRe, dataOutRe);
	endtask

	// One clock cycle checks at 2 ns, drives the inputs and then notes
	// whether the sample will be taken.
	task automatic stepCycle(input logic en, input logic stop, input sampleType sample);
		@(posedge clock);
		#2;
		checkOutputs();
		enable = en;
		stopDataIn = stop;
		dataIn = sample;
		#1;
		assert (!(sampleReady && (!en || stop || stopSeen))) else
			reportMismatch("sampleReady", 0, 1);
		pendAccept = sampleReady;
		pendEnable = en;
		pendSample = sample;
		if (!en) begin
			stopSeen = 1'b0;
		end else if (stop) begin
			stopSeen = 1'b1;
		end
	endtask

	initial begin
		int total;
		int waited;
		sampleType sample;
		enable = 1'b0;
		stopDataIn = 1'b0;
		dataIn = '0;
		rstN = 1'b0;
		pendAccept = 1'b0;
		pendEnable = 1'b0;
		pendSample = '0;
		stopSeen = 1'b0;
		accepted = 0;
		valueErrors = 0;
		otherErrors = 0;
		limitCycles = 0;
		lfsrState = 32'h06c0_c7b8;
		foreach (kernel[j]) begin
			kernel[j] = refTap(j);
			hist[j] = 0;
		end
		// Idle, start, zero fill, impulse, step, random, stop, restart.
		addEntry(1'b0, 1'b0, modeConst, 0, 6, 1'b0);
		addEntry(1'b1, 1'b0, modeWait, 0, 40, 1'b1);
		addEntry(1'b1, 1'b0, modeConst, 0, 30, 1'b1);
		addEntry(1'b1, 1'b0, modeImpulse, 20000, 30, 1'b1);
		addEntry(1'b1, 1'b0, modeConst, -12345, 35, 1'b1);
		addEntry(1'b1, 1'b0, modeRandom, 0, 60, 1'b1);
		addEntry(1'b1, 1'b1, modeConst, 0, 4, 1'b0);
		addEntry(1'b1, 1'b0, modeConst, 777, 5, 1'b0);
		addEntry(1'b0, 1'b0, modeConst, 0, 4, 1'b0);
		addEntry(1'b1, 1'b0, modeWait, 0, 40, 1'b1);
		addEntry(1'b1, 1'b0, modeRandom, 0, 45, 1'b1);
		addEntry(1'b1, 1'b1, modeConst, 0, 3, 1'b0);
		addEntry(1'b0, 1'b0, modeConst, 0, 3, 1'b0);
		total = 0;
		foreach (stimulus[e]) begin
			total += stimulus[e].count;
		end
		limitCycles = total + 4 + 50;
		repeat (4) @(posedge clock);
		#2;
		rstN = 1'b1;
		foreach (stimulus[e]) begin
			if (stimulus[e].mode == modeWait) begin
				waited = 0;
				while (!pendAccept && waited < stimulus[e].count) begin
					stepCycle(stimulus[e].en, stimulus[e].stop, '0);
					waited++;
				end
				assert (pendAccept) else begin
					otherErrors++;
					$display("%0t sampleReady never rose within %0d cycles of enable.", $time,
						stimulus[e].count);
				end
			end else begin
				for (int i = 0; i < stimulus[e].count; i++) begin
					case (stimulus[e].mode)
						modeImpulse: sample = (i == 0) ? sampleType'(stimulus[e].value) : '0;
						modeRandom: sample = randomSample();
						default: sample = sampleType'(stimulus[e].value);
					endcase
					stepCycle(stimulus[e].en, stimulus[e].stop, sample);
				end
			end
			assert (pendAccept === stimulus[e].readyAtEnd) else
				reportMismatch("sampleReady", longint'(stimulus[e].readyAtEnd),
					longint'(pendAccept));
		end
		$display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
		if (valueErrors + otherErrors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule
